/* Bender.yml */
package:
  name: cache

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cache_pkg.sv
      - hw/cache_way_array.sv
      - hw/cache_plru.sv
      - hw/cache_lookup.sv
      - hw/cache_ctrl.sv
      - hw/cache_dfp_port.sv
      - hw/cache.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_clk_gen.sv
      - dv/cache_mem_resp.sv
      - dv/cache_sva.sv
      - dv/cache_tb.sv

/* cache.f */
+incdir+hw
hw/cache_pkg.sv
hw/cache_way_array.sv
hw/cache_plru.sv
hw/cache_lookup.sv
hw/cache_ctrl.sv
hw/cache_dfp_port.sv
hw/cache.sv
dv/tb_clk_gen.sv
dv/cache_mem_resp.sv
dv/cache_sva.sv
dv/cache_tb.sv

/* dv/cache_mem_resp.sv */
`default_nettype none

`include "cache_params.svh"

module cache_mem_resp (
    input  logic             clk,
    input  logic             rst_n,
    input  cache_pkg::addr_t dfp_addr,
    input  logic             dfp_read,
    input  logic             dfp_write,
    input  cache_pkg::line_t dfp_wdata,
    output cache_pkg::line_t dfp_rdata,
    output logic             dfp_resp
);
    import cache_pkg::*;

    line_t  mem [addr_t];
    integer seed;
    int     wait_cnt;
    logic   busy;

    // each byte is a hash of its full byte address
    function automatic line_t fill_line(input addr_t base);
        line_t       l;
        logic [31:0] h;
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            h = (base + b) * 32'h9e3779b1;
            l[8*b +: 8] = h[31:24];
        end
        return l;
    endfunction

    initial begin
        seed      = 32'h40eac07f;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        busy      = 1'b0;
        wait_cnt  = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst_n || dfp_resp) begin
                dfp_resp = 1'b0;
                busy     = 1'b0;
            end else if (dfp_read || dfp_write) begin
                // latency of 1 to 8 cycles per request
                if (!busy) begin
                    busy     = 1'b1;
                    wait_cnt = $unsigned($random(seed)) % 8;
                end
                if (wait_cnt == 0) begin
                    if (dfp_write) begin
                        mem[dfp_addr] = dfp_wdata;
                    end else if (mem.exists(dfp_addr)) begin
                        dfp_rdata = mem[dfp_addr];
                    end else begin
                        dfp_rdata = fill_line(dfp_addr);
                    end
                    dfp_resp = 1'b1;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/cache_sva.sv */
`default_nettype none

`include "cache_params.svh"

module cache_sva (
    input logic             clk,
    input logic             rst_n,
    input logic             ufp_resp,
    input cache_pkg::addr_t dfp_addr,
    input logic             dfp_read,
    input logic             dfp_write,
    input cache_pkg::line_t dfp_wdata,
    input logic             dfp_resp
);

    int unsigned sva_errors = 0;

    one_direction: assert property (@(posedge clk) disable iff (!rst_n)
        !(dfp_read && dfp_write))
    else begin
        $error("dfp_read and dfp_write high together");
        sva_errors++;
    end

    read_held: assert property (@(posedge clk) disable iff (!rst_n)
        (dfp_read && !dfp_resp) |=> (dfp_read && $stable(dfp_addr)))
    else begin
        $error("dfp read request dropped or changed before dfp_resp");
        sva_errors++;
    end

    write_held: assert property (@(posedge clk) disable iff (!rst_n)
        (dfp_write && !dfp_resp) |=>
            (dfp_write && $stable(dfp_addr) && $stable(dfp_wdata)))
    else begin
        $error("dfp write request dropped or changed before dfp_resp");
        sva_errors++;
    end

    resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ufp_resp |=> !ufp_resp)
    else begin
        $error("ufp_resp longer than one cycle");
        sva_errors++;
    end

    line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (dfp_read || dfp_write) |-> (dfp_addr[`CACHE_OFFSET_W-1:0] == '0))
    else begin
        $error("dfp_addr not line aligned");
        sva_errors++;
    end

endmodule

bind cache cache_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .ufp_resp  (ufp_resp),
    .dfp_addr  (dfp_addr),
    .dfp_read  (dfp_read),
    .dfp_write (dfp_write),
    .dfp_wdata (dfp_wdata),
    .dfp_resp  (dfp_resp)
);

`default_nettype wire

/* dv/cache_tb.sv */
`default_nettype none

`include "cache_params.svh"

module cache_tb;
    import cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 400;

    logic  clk;
    logic  rst_n;
    addr_t ufp_addr;
    mask_t ufp_rmask;
    mask_t ufp_wmask;
    word_t ufp_wdata;
    word_t ufp_rdata;
    logic  ufp_resp;
    addr_t dfp_addr;
    logic  dfp_read;
    logic  dfp_write;
    line_t dfp_rdata;
    line_t dfp_wdata;
    logic  dfp_resp;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     test_errors;
    int     writebacks;

    // reference model, CPU byte view plus shadow tag state
    logic [7:0] byte_mem [addr_t];
    tag_t       m_tag    [`CACHE_SETS][`CACHE_WAYS];
    logic       m_valid  [`CACHE_SETS][`CACHE_WAYS];
    logic       m_dirty  [`CACHE_SETS][`CACHE_WAYS];
    plru_bits_t m_plru   [`CACHE_SETS];

    tb_clk_gen #(.PERIOD(4)) u_clk (.clk(clk));

    cache cache_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_wdata (ufp_wdata),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_rdata (dfp_rdata),
        .dfp_wdata (dfp_wdata),
        .dfp_resp  (dfp_resp)
    );

    cache_mem_resp u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("ERROR %0t %s", $time, what);
        test_errors++;
    endtask

    task automatic end_test(input string name);
        $display("test %s done with %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
        tests++;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("ERROR %0t no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    endtask

    // memory contents before any write: hash of the byte address
    function automatic logic [7:0] pattern_byte(input addr_t a);
        logic [31:0] h;
        h = a * 32'h9e3779b1;
        return h[31:24];
    endfunction

    function automatic logic [7:0] model_byte(input addr_t a);
        if (byte_mem.exists(a)) begin
            return byte_mem[a];
        end
        return pattern_byte(a);
    endfunction

    function automatic line_t model_line(input addr_t base);
        line_t l;
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            l[8*b +: 8] = model_byte(base + b);
        end
        return l;
    endfunction

    // tree: bit 0 root, bit 1 pair 0/1, bit 2 pair 2/3
    function automatic way_t plru_victim(input plru_bits_t bits);
        if (!bits[0]) begin
            return bits[1] ? way_t'(1) : way_t'(0);
        end
        return bits[2] ? way_t'(3) : way_t'(2);
    endfunction

    function automatic plru_bits_t plru_touch(input plru_bits_t bits, input way_t w);
        plru_bits_t n;
        n = bits;
        n[0] = (w < 2);
        if (w < 2) begin
            n[1] = (w == 0);
        end else begin
            n[2] = (w == 2);
        end
        return n;
    endfunction

    function automatic addr_t rand_addr(input int n_sets, input int n_tags);
        tag_t       t;
        set_idx_t   s;
        logic [2:0] w;
        t = tag_t'(23'h15a00 + 23'h2c1 * ($unsigned($random(seed)) % n_tags));
        s = set_idx_t'($unsigned($random(seed)) % n_sets);
        w = 3'($random(seed));
        return {t, s, w, 2'b00};
    endfunction

    function automatic mask_t rand_wmask();
        mask_t m;
        m = 4'($random(seed));
        if (m == '0) begin
            m = 4'hf;
        end
        return m;
    endfunction

    // one CPU request, checked against the model, then the model is updated
    task automatic access(input addr_t addr, input mask_t rmask, input mask_t wmask,
                          input word_t wdata, output int lat);
        set_idx_t s;
        tag_t     t;
        way_t     way;
        logic     hit;
        addr_t    base;
        addr_t    wa;
        addr_t    vbase;
        word_t    got_rdata;
        word_t    exp_rdata;
        logic     exp_write [$];
        addr_t    exp_addr  [$];
        line_t    exp_data  [$];
        logic     got_write [$];
        addr_t    got_addr  [$];
        line_t    got_data  [$];

        s    = addr[`CACHE_OFFSET_W +: `CACHE_SET_W];
        t    = addr[31 -: `CACHE_TAG_W];
        base = {addr[31:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
        wa   = {addr[31:2], 2'b00};
        hit  = 1'b0;
        way  = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        if (!hit) begin
            way = plru_victim(m_plru[s]);
            if (m_valid[s][way] && m_dirty[s][way]) begin
                vbase = {m_tag[s][way], s, {`CACHE_OFFSET_W{1'b0}}};
                exp_write.push_back(1'b1);
                exp_addr.push_back(vbase);
                exp_data.push_back(model_line(vbase));
                writebacks++;
            end
            exp_write.push_back(1'b0);
            exp_addr.push_back(base);
            exp_data.push_back('0);
        end

        @(posedge clk);
        #1;
        ufp_addr  = addr;
        ufp_rmask = rmask;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (dfp_resp) begin
                got_write.push_back(dfp_write);
                got_addr.push_back(dfp_addr);
                got_data.push_back(dfp_wdata);
            end
        end while (!ufp_resp && lat < TIMEOUT_CYCLES);

        if (!ufp_resp) begin
            abort_on_timeout("ufp_resp");
        end else begin
            got_rdata = ufp_rdata;
            lat       = lat - 1;
            if (got_write.size() != exp_write.size()) begin
                note_failure($sformatf("%0d memory transfers for %h, expected %0d",
                                       got_write.size(), addr, exp_write.size()));
            end else begin
                foreach (exp_write[i]) begin
                    check_flag("dfp_write", got_write[i], exp_write[i]);
                    check_addr("dfp_addr", got_addr[i], exp_addr[i]);
                    if (exp_write[i]) begin
                        check_line("dfp_wdata", got_data[i], exp_data[i]);
                    end
                end
            end
            if (hit && lat != 1) begin
                note_failure($sformatf("hit on %h answered after %0d cycles, expected 1",
                                       addr, lat));
            end
            if (rmask != '0) begin
                for (int b = 0; b < 4; b++) begin
                    exp_rdata[8*b +: 8] = model_byte(wa + b);
                end
                check_word("ufp_rdata", got_rdata, exp_rdata);
            end
            if (!hit) begin
                m_tag[s][way]   = t;
                m_valid[s][way] = 1'b1;
                m_dirty[s][way] = 1'b0;
            end
            if (wmask != '0) begin
                for (int b = 0; b < 4; b++) begin
                    if (wmask[b]) begin
                        byte_mem[wa + b] = wdata[8*b +: 8];
                    end
                end
                m_dirty[s][way] = 1'b1;
            end
            m_plru[s] = plru_touch(m_plru[s], way);
        end
    endtask

    initial begin
        int       lat;
        int       j;
        int       tmp;
        int       order [4];
        tag_t     fill  [4];
        tag_t     ev_tag;
        set_idx_t rs;
        addr_t    a;

        seed        = 32'h40eac07f;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_errors = 0;
        writebacks  = 0;
        rst_n       = 1'b0;
        ufp_addr    = '0;
        ufp_rmask   = '0;
        ufp_wmask   = '0;
        ufp_wdata   = '0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        check_flag("ufp_resp", ufp_resp, 1'b0);
        check_flag("dfp_read", dfp_read, 1'b0);
        check_flag("dfp_write", dfp_write, 1'b0);
        access(rand_addr(4, 6), 4'hf, '0, '0, lat);
        end_test("reset");

        repeat (60) begin
            access(rand_addr(4, 6), 4'hf, '0, '0, lat);
        end
        end_test("read");

        // write then read back the same word, the read must hit
        repeat (30) begin
            a = rand_addr(4, 6);
            access(a, '0, rand_wmask(), $random(seed), lat);
            access(a, 4'hf, '0, '0, lat);
        end
        end_test("write");

        writebacks = 0;
        repeat (80) begin
            a = rand_addr(2, 8);
            if ($random(seed) & 1) begin
                access(a, '0, rand_wmask(), $random(seed), lat);
            end else begin
                access(a, 4'hf, '0, '0, lat);
            end
        end
        if (writebacks == 0) begin
            note_failure("no dirty eviction happened during the eviction test");
        end
        end_test("evict");

        for (int k = 0; k < 4; k++) begin
            rs = set_idx_t'($random(seed));
            for (int i = 0; i < 4; i++) begin
                fill[i]  = tag_t'(23'h400000 + 16 * k + i);
                order[i] = i;
                access({fill[i], rs, 5'b0}, 4'hf, '0, '0, lat);
            end
            for (int i = 3; i > 0; i--) begin
                j        = $unsigned($random(seed)) % (i + 1);
                tmp      = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
            for (int i = 0; i < 4; i++) begin
                access({fill[order[i]], rs, 5'b0}, 4'hf, '0, '0, lat);
            end
            ev_tag = m_tag[rs][plru_victim(m_plru[rs])];
            access({tag_t'(23'h400000 + 16 * k + 4), rs, 5'b0}, 4'hf, '0, '0, lat);
            // survivors hit, the evicted tag has to be fetched again
            for (int i = 0; i < 4; i++) begin
                if (fill[i] != ev_tag) begin
                    access({fill[i], rs, 5'b0}, 4'hf, '0, '0, lat);
                end
            end
            access({ev_tag, rs, 5'b0}, 4'hf, '0, '0, lat);
        end
        end_test("replace");

        @(posedge clk);
        #1;
        ufp_rmask = '0;
        ufp_wmask = '0;
        repeat (2) @(posedge clk);
        errors += cache_inst.u_sva.sva_errors;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* hw/cache.sv */
`default_nettype none

`include "cache_params.svh"

module cache (
    input  logic             clk,
    input  logic             rst_n,
    input  cache_pkg::addr_t ufp_addr,
    input  cache_pkg::mask_t ufp_rmask,
    input  cache_pkg::mask_t ufp_wmask,
    input  cache_pkg::word_t ufp_wdata,
    output cache_pkg::word_t ufp_rdata,
    output logic             ufp_resp,
    output cache_pkg::addr_t dfp_addr,
    output logic             dfp_read,
    output logic             dfp_write,
    input  cache_pkg::line_t dfp_rdata,
    output cache_pkg::line_t dfp_wdata,
    input  logic             dfp_resp
);
    import cache_pkg::*;

    tag_t  [`CACHE_WAYS-1:0] way_tag;
    logic  [`CACHE_WAYS-1:0] way_valid;
    logic  [`CACHE_WAYS-1:0] way_dirty;
    line_t [`CACHE_WAYS-1:0] way_data;
    logic  [`CACHE_WAYS-1:0] way_wr_en;

    lookup_t    result;
    way_t       hit_way;
    way_t       victim;
    tag_t       victim_tag;
    tag_t       req_tag;
    set_idx_t   set_idx;
    line_t      merge_data;
    line_mask_t merge_mask;
    line_t      wr_data;
    line_mask_t wr_mask;
    logic       rd_en;
    logic       hit_write;
    logic       refill;
    logic       mem_read;
    logic       mem_write;
    logic       plru_touch;

    assign set_idx = ufp_addr[`CACHE_OFFSET_W +: `CACHE_SET_W];
    assign req_tag = ufp_addr[31 -: `CACHE_TAG_W];

    // refill writes the whole line clean, a hit write merges and dirties
    assign wr_data = refill ? dfp_rdata : merge_data;
    assign wr_mask = refill ? '1 : merge_mask;

    generate
        for (genvar i = 0; i < `CACHE_WAYS; i++) begin : g_way
            assign way_wr_en[i] = (hit_write && (hit_way == way_t'(i)))
                               || (refill && (victim == way_t'(i)));

            cache_way_array u_way (
                .clk      (clk),
                .rst_n    (rst_n),
                .rd_en    (rd_en),
                .set      (set_idx),
                .wr_en    (way_wr_en[i]),
                .wr_mask  (wr_mask),
                .wr_data  (wr_data),
                .wr_tag   (req_tag),
                .wr_dirty (hit_write),
                .rd_data  (way_data[i]),
                .rd_tag   (way_tag[i]),
                .rd_dirty (way_dirty[i]),
                .rd_valid (way_valid[i])
            );
        end
    endgenerate

    cache_lookup u_lookup (
        .ufp_addr   (ufp_addr),
        .ufp_wmask  (ufp_wmask),
        .ufp_wdata  (ufp_wdata),
        .way_tag    (way_tag),
        .way_valid  (way_valid),
        .way_dirty  (way_dirty),
        .way_data   (way_data),
        .victim     (victim),
        .result     (result),
        .hit_way    (hit_way),
        .rd_word    (ufp_rdata),
        .merge_data (merge_data),
        .merge_mask (merge_mask),
        .victim_tag (victim_tag)
    );

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .ufp_rmask  (ufp_rmask),
        .ufp_wmask  (ufp_wmask),
        .result     (result),
        .dfp_resp   (dfp_resp),
        .rd_en      (rd_en),
        .hit_write  (hit_write),
        .refill     (refill),
        .ufp_resp   (ufp_resp),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .plru_touch (plru_touch)
    );

    cache_plru u_plru (
        .clk       (clk),
        .rst_n     (rst_n),
        .set       (set_idx),
        .touch     (plru_touch),
        .touch_way (hit_way),
        .victim    (victim)
    );

    cache_dfp_port u_dfp_port (
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .ufp_addr    (ufp_addr),
        .victim_tag  (victim_tag),
        .victim_data (way_data[victim]),
        .dfp_addr    (dfp_addr),
        .dfp_read    (dfp_read),
        .dfp_write   (dfp_write),
        .dfp_wdata   (dfp_wdata)
    );

endmodule

`default_nettype wire

/* hw/cache_ctrl.sv */
`default_nettype none

module cache_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  cache_pkg::mask_t   ufp_rmask,
    input  cache_pkg::mask_t   ufp_wmask,
    input  cache_pkg::lookup_t result,
    input  logic               dfp_resp,
    output logic               rd_en,
    output logic               hit_write,
    output logic               refill,
    output logic               ufp_resp,
    output logic               mem_read,
    output logic               mem_write,
    output logic               plru_touch
);
    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        req;

    assign req = (ufp_rmask != '0) || (ufp_wmask != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        rd_en      = 1'b0;
        hit_write  = 1'b0;
        refill     = 1'b0;
        ufp_resp   = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        plru_touch = 1'b0;
        case (state)
            st_idle: begin
                // arrays read on this edge, tags compared next cycle
                if (req) begin
                    rd_en      = 1'b1;
                    state_next = st_compare;
                end
            end
            st_compare: begin
                case (result)
                    lk_hit: begin
                        ufp_resp   = 1'b1;
                        plru_touch = 1'b1;
                        hit_write  = (ufp_wmask != '0);
                        state_next = st_idle;
                    end
                    lk_dirty_miss: begin
                        state_next = st_writeback;
                    end
                    default: begin
                        state_next = st_allocate;
                    end
                endcase
            end
            st_writeback: begin
                mem_write = 1'b1;
                if (dfp_resp) begin
                    state_next = st_allocate;
                end
            end
            st_allocate: begin
                mem_read = 1'b1;
                if (dfp_resp) begin
                    refill     = 1'b1;
                    state_next = st_refill_wait;
                end
            end
            st_refill_wait: begin
                // re-read so compare sees the new line
                rd_en      = 1'b1;
                state_next = st_compare;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/cache_dfp_port.sv */
`default_nettype none

`include "cache_params.svh"

module cache_dfp_port (
    input  logic             mem_read,
    input  logic             mem_write,
    input  cache_pkg::addr_t ufp_addr,
    input  cache_pkg::tag_t  victim_tag,
    input  cache_pkg::line_t victim_data,
    output cache_pkg::addr_t dfp_addr,
    output logic             dfp_read,
    output logic             dfp_write,
    output cache_pkg::line_t dfp_wdata
);
    import cache_pkg::*;

    set_idx_t set_idx;
    tag_t     req_tag;

    assign set_idx = ufp_addr[`CACHE_OFFSET_W +: `CACHE_SET_W];
    assign req_tag = ufp_addr[31 -: `CACHE_TAG_W];

    // cache_ctrl raises at most one of these
    assign dfp_write = mem_write;
    assign dfp_read  = mem_read;

    always_comb begin
        dfp_addr  = '0;
        dfp_wdata = '0;
        if (dfp_write) begin
            dfp_addr  = {victim_tag, set_idx, {`CACHE_OFFSET_W{1'b0}}};
            dfp_wdata = victim_data;
        end else if (dfp_read) begin
            dfp_addr = {req_tag, set_idx, {`CACHE_OFFSET_W{1'b0}}};
        end
    end

endmodule

`default_nettype wire

/* hw/cache_lookup.sv */
`default_nettype none

`include "cache_params.svh"

module cache_lookup (
    input  cache_pkg::addr_t                   ufp_addr,
    input  cache_pkg::mask_t                   ufp_wmask,
    input  cache_pkg::word_t                   ufp_wdata,
    input  cache_pkg::tag_t  [`CACHE_WAYS-1:0] way_tag,
    input  logic             [`CACHE_WAYS-1:0] way_valid,
    input  logic             [`CACHE_WAYS-1:0] way_dirty,
    input  cache_pkg::line_t [`CACHE_WAYS-1:0] way_data,
    input  cache_pkg::way_t                    victim,
    output cache_pkg::lookup_t                 result,
    output cache_pkg::way_t                    hit_way,
    output cache_pkg::word_t                   rd_word,
    output cache_pkg::line_t                   merge_data,
    output cache_pkg::line_mask_t              merge_mask,
    output cache_pkg::tag_t                    victim_tag
);
    import cache_pkg::*;

    tag_t                       req_tag;
    logic [`CACHE_OFFSET_W-3:0] word_idx;
    logic [`CACHE_WAYS-1:0]     tag_match;
    line_t                      hit_line;

    assign req_tag  = ufp_addr[31 -: `CACHE_TAG_W];
    assign word_idx = ufp_addr[`CACHE_OFFSET_W-1:2];

    // at most one way can match
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            tag_match[w] = way_valid[w] && (way_tag[w] == req_tag);
            if (tag_match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    always_comb begin
        if (|tag_match) begin
            result = lk_hit;
        end else if (way_valid[victim] && way_dirty[victim]) begin
            result = lk_dirty_miss;
        end else begin
            result = lk_clean_miss;
        end
    end

    assign hit_line   = way_data[hit_way];
    assign rd_word    = hit_line[32*word_idx +: 32];
    assign victim_tag = way_tag[victim];

    // write word merged into the hit line at its word offset
    always_comb begin
        merge_mask = '0;
        merge_mask[4*word_idx +: 4] = ufp_wmask;
        merge_data = hit_line;
        for (int b = 0; b < 4; b++) begin
            if (ufp_wmask[b]) begin
                merge_data[32*word_idx + 8*b +: 8] = ufp_wdata[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// geometry of the 4-way, 16-set cache
`define CACHE_WAYS       4
`define CACHE_SETS       16
`define CACHE_LINE_BYTES 32

// address split: tag | set | byte offset
`define CACHE_TAG_W      23
`define CACHE_SET_W      4
`define CACHE_OFFSET_W   5

`endif

/* hw/cache_pkg.sv */
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

    typedef logic [31:0]                      addr_t;
    typedef logic [31:0]                      word_t;
    typedef logic [3:0]                       mask_t;
    typedef logic [`CACHE_LINE_BYTES*8-1:0]   line_t;
    typedef logic [`CACHE_LINE_BYTES-1:0]     line_mask_t;
    typedef logic [`CACHE_TAG_W-1:0]          tag_t;
    typedef logic [`CACHE_SET_W-1:0]          set_idx_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0]   way_t;
    // root bit, pair 0/1 bit, pair 2/3 bit
    typedef logic [`CACHE_WAYS-2:0]           plru_bits_t;

    typedef enum logic [1:0] {
        lk_hit,
        lk_clean_miss,
        lk_dirty_miss
    } lookup_t;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_allocate,
        st_refill_wait
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hw/cache_plru.sv */
`default_nettype none

`include "cache_params.svh"

module cache_plru (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::set_idx_t set,
    input  logic                touch,
    input  cache_pkg::way_t     touch_way,
    output cache_pkg::way_t     victim
);
    import cache_pkg::*;

    plru_bits_t tree [`CACHE_SETS];
    plru_bits_t cur_bits;
    plru_bits_t next_bits;

    assign cur_bits = tree[set];

    // root 0 -> ways 0/1, root 1 -> ways 2/3
    always_comb begin
        if (!cur_bits[0]) begin
            victim = cur_bits[1] ? 2'd1 : 2'd0;
        end else begin
            victim = cur_bits[2] ? 2'd3 : 2'd2;
        end
    end

    // point the touched path away from the touched way
    always_comb begin
        next_bits = cur_bits;
        case (touch_way)
            2'd0: begin
                next_bits[0] = 1'b1;
                next_bits[1] = 1'b1;
            end
            2'd1: begin
                next_bits[0] = 1'b1;
                next_bits[1] = 1'b0;
            end
            2'd2: begin
                next_bits[0] = 1'b0;
                next_bits[2] = 1'b1;
            end
            default: begin
                next_bits[0] = 1'b0;
                next_bits[2] = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[set] <= next_bits;
        end
    end

endmodule

`default_nettype wire

/* hw/cache_way_array.sv */
`default_nettype none

`include "cache_params.svh"

module cache_way_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rd_en,
    input  cache_pkg::set_idx_t   set,
    input  logic                  wr_en,
    input  cache_pkg::line_mask_t wr_mask,
    input  cache_pkg::line_t      wr_data,
    input  cache_pkg::tag_t       wr_tag,
    input  logic                  wr_dirty,
    output cache_pkg::line_t      rd_data,
    output cache_pkg::tag_t       rd_tag,
    output logic                  rd_dirty,
    output logic                  rd_valid
);
    import cache_pkg::*;

    line_t                  data_mem  [`CACHE_SETS];
    tag_t                   tag_mem   [`CACHE_SETS];
    logic                   dirty_mem [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_mem;

    // byte-enabled line store plus tag and dirty
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
                if (wr_mask[b]) begin
                    data_mem[set][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
            tag_mem[set]   <= wr_tag;
            dirty_mem[set] <= wr_dirty;
        end
    end

    // synchronous read port, holds its output while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data  <= data_mem[set];
            rd_tag   <= tag_mem[set];
            rd_dirty <= dirty_mem[set];
            rd_valid <= valid_mem[set];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_mem <= '0;
        end else if (wr_en) begin
            valid_mem[set] <= 1'b1;
        end
    end

endmodule

`default_nettype wire
